/* Bender.yml */
package:
  name: virtual_console

sources:
  - files:
      - design/consolePkg.sv
      - design/UartReceiver.sv
      - design/ByteQueue.sv
      - design/Vt100Parser.sv
      - design/TextRam.sv
      - design/VirtualConsole.sv
  - target: test
    files:
      - tb/VirtualConsoleTb.sv

/* VirtualConsole.f */
design/consolePkg.sv
design/UartReceiver.sv
design/ByteQueue.sv
design/Vt100Parser.sv
design/TextRam.sv
design/VirtualConsole.sv
tb/VirtualConsoleTb.sv

/* design/ByteQueue.sv */
`timescale 1ns/1ns

module ByteQueue (
    input  logic       clk,
    input  logic       arstN,
    input  logic       rxValid,
    input  logic [7:0] rxByte,
    input  logic       creditReturn,
    output logic       byteValid,
    output logic [7:0] byteData
);

    localparam int ptrWidth = $clog2(consolePkg::queueDepth);

    logic [7:0] mem [consolePkg::queueDepth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [$clog2(consolePkg::queueDepth + 1)-1:0] fill;
    logic [$clog2(consolePkg::parserSlots + 1)-1:0] credits;

    logic full;
    logic push;
    logic send;

    assign full = (fill == ($clog2(consolePkg::queueDepth + 1))'(consolePkg::queueDepth));
    // no back-pressure on the line, extra frames are lost
    assign push = rxValid & ~full;
    // head goes out only while the parser has room
    assign send = (fill != '0) & (credits != '0);

    assign byteValid = send;
    assign byteData = mem[rdPtr];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (send) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // push and send together leave fill as is
            fill <= fill + push - send;
        end
    end

    // credits start at parser slot count
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            credits <= ($clog2(consolePkg::parserSlots + 1))'(consolePkg::parserSlots);
        end else begin
            credits <= credits + creditReturn - send;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= rxByte;
        end
    end

endmodule

/* design/TextRam.sv */
`timescale 1ns/1ns

module TextRam (
    input  logic                                clk,
    input  logic                                ramWrite,
    input  logic [consolePkg::cellAddrWidth-1:0] ramAddr,
    input  logic [7:0]                          ramData,
    input  logic [consolePkg::cellAddrWidth-1:0] readAddr,
    output logic [7:0]                          readData
);

    // one byte per text cell
    logic [7:0] mem [consolePkg::screenCells];

    // parser side write
    always_ff @(posedge clk) begin
        if (ramWrite) begin
            mem[ramAddr] <= ramData;
        end
    end

    // display side, registered read
    // same-edge write to the same cell gives the old byte
    always_ff @(posedge clk) begin
        readData <= mem[readAddr];
    end

endmodule

/* design/UartReceiver.sv */
`timescale 1ns/1ns

module UartReceiver (
    input  logic       clk,
    input  logic       arstN,
    input  logic       uartRx,
    output logic       rxValid,
    output logic [7:0] rxByte
);

    typedef enum logic [2:0] {
        idle,
        startBit,
        dataBits,
        stopBit,
        stopTail
    } rxState_t;

    rxState_t state;

    // two-flop synchronizer plus delayed copy for edge detect
    logic rxMeta;
    logic rxSync;
    logic rxPrev;
    logic fallingEdge;

    logic [$clog2(consolePkg::clocksPerBit)-1:0] tick;
    logic [2:0] bitIndex;
    logic [7:0] shiftReg;

    assign fallingEdge = rxPrev & ~rxSync;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            // idle line is high
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end else begin
            rxMeta <= uartRx;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
            tick <= '0;
            bitIndex <= '0;
            rxValid <= 1'b0;
        end else begin
            rxValid <= 1'b0;
            tick <= tick + 1'b1;
            case (state)
                idle: begin
                    if (fallingEdge) begin
                        state <= startBit;
                        tick <= '0;
                    end
                end
                startBit: begin
                    // middle of start bit, still low or a glitch
                    if (tick == ($clog2(consolePkg::clocksPerBit))'(consolePkg::clocksPerBit / 2 - 1)) begin
                        tick <= '0;
                        bitIndex <= '0;
                        state <= rxSync ? idle : dataBits;
                    end
                end
                dataBits: begin
                    if (&tick) begin
                        bitIndex <= bitIndex + 1'b1;
                        // last data bit sampled
                        if (&bitIndex) begin
                            state <= stopBit;
                        end
                    end
                end
                stopBit: begin
                    // bad stop bit drops the frame
                    if (&tick) begin
                        state <= rxSync ? stopTail : idle;
                    end
                end
                stopTail: begin
                    // strobe just before the stop bit ends, so the next start edge is seen
                    if (tick == ($clog2(consolePkg::clocksPerBit))'(consolePkg::clocksPerBit / 2 - 2)) begin
                        rxValid <= 1'b1;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // lsb first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == dataBits && (&tick)) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
    end

    assign rxByte = shiftReg;

endmodule

/* design/VirtualConsole.sv */
`timescale 1ns/1ns

module VirtualConsole (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                uartRx,
    input  logic [consolePkg::cellAddrWidth-1:0] readAddr,
    output logic [7:0]                          readData,
    output logic [consolePkg::rowWidth-1:0]     cursorRow,
    output logic [consolePkg::colWidth-1:0]     cursorCol
);

    // receiver to queue
    logic       rxValid;
    logic [7:0] rxByte;

    // queue to parser, credit based
    logic       byteValid;
    logic [7:0] byteData;
    logic       creditReturn;

    // parser to screen memory
    logic                                ramWrite;
    logic [consolePkg::cellAddrWidth-1:0] ramAddr;
    logic [7:0]                          ramData;

    UartReceiver u_rx (
        .clk     (clk),
        .arstN   (arstN),
        .uartRx  (uartRx),
        .rxValid (rxValid),
        .rxByte  (rxByte)
    );

    ByteQueue u_queue (
        .clk          (clk),
        .arstN        (arstN),
        .rxValid      (rxValid),
        .rxByte       (rxByte),
        .creditReturn (creditReturn),
        .byteValid    (byteValid),
        .byteData     (byteData)
    );

    Vt100Parser u_parser (
        .clk          (clk),
        .arstN        (arstN),
        .byteValid    (byteValid),
        .byteData     (byteData),
        .creditReturn (creditReturn),
        .ramWrite     (ramWrite),
        .ramAddr      (ramAddr),
        .ramData      (ramData),
        .cursorRow    (cursorRow),
        .cursorCol    (cursorCol)
    );

    // read port stands in for the display engine
    TextRam u_ram (
        .clk      (clk),
        .ramWrite (ramWrite),
        .ramAddr  (ramAddr),
        .ramData  (ramData),
        .readAddr (readAddr),
        .readData (readData)
    );

endmodule

/* design/Vt100Parser.sv */
`timescale 1ns/1ns

module Vt100Parser (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                byteValid,
    input  logic [7:0]                          byteData,
    output logic                                creditReturn,
    output logic                                ramWrite,
    output logic [consolePkg::cellAddrWidth-1:0] ramAddr,
    output logic [7:0]                          ramData,
    output logic [consolePkg::rowWidth-1:0]     cursorRow,
    output logic [consolePkg::colWidth-1:0]     cursorCol
);

    typedef enum logic [1:0] {
        ground,
        escape,
        csi,
        clearing
    } parseState_t;

    parseState_t state;

    // input slots, sized by the credits the queue holds
    logic [7:0] slotData [consolePkg::parserSlots];
    logic [$clog2(consolePkg::parserSlots)-1:0] wrSlot;
    logic [$clog2(consolePkg::parserSlots)-1:0] rdSlot;
    logic [$clog2(consolePkg::parserSlots + 1)-1:0] slotCount;

    logic pop;
    logic [7:0] curByte;
    logic printable;
    logic lastCol;
    logic lastRow;
    logic [consolePkg::cellAddrWidth-1:0] sweep;

    // no new byte while the clear sweep runs
    assign pop = (state != clearing) & (slotCount != '0);
    assign curByte = slotData[rdSlot];
    assign printable = (curByte >= consolePkg::charFirstPrint) &&
                       (curByte <= consolePkg::charLastPrint);
    assign lastCol = (cursorCol == consolePkg::colWidth'(consolePkg::screenCols - 1));
    assign lastRow = (cursorRow == consolePkg::rowWidth'(consolePkg::screenRows - 1));

    // power-of-two columns, so row * screenCols + col is a concatenation
    always_comb begin
        if (state == clearing) begin
            ramWrite = 1'b1;
            ramAddr = sweep;
            ramData = consolePkg::charSpace;
        end else begin
            ramWrite = pop && (state == ground) && printable;
            ramAddr = {cursorRow, cursorCol};
            ramData = curByte;
        end
    end

    always_ff @(posedge clk) begin
        if (byteValid) begin
            slotData[wrSlot] <= byteData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrSlot <= '0;
            rdSlot <= '0;
            slotCount <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (byteValid) begin
                wrSlot <= wrSlot + 1'b1;
            end
            if (pop) begin
                rdSlot <= rdSlot + 1'b1;
            end
            slotCount <= slotCount + byteValid - pop;
            // one credit back per byte taken
            creditReturn <= pop;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= ground;
            cursorRow <= '0;
            cursorCol <= '0;
            sweep <= '0;
        end else begin
            case (state)
                ground: begin
                    if (pop) begin
                        if (printable) begin
                            // wrap right edge to next row, last row to row 0
                            cursorCol <= lastCol ? '0 : cursorCol + 1'b1;
                            if (lastCol) begin
                                cursorRow <= lastRow ? '0 : cursorRow + 1'b1;
                            end
                        end else if (curByte == consolePkg::charCr) begin
                            cursorCol <= '0;
                        end else if (curByte == consolePkg::charLf) begin
                            // column kept, no scroll
                            cursorRow <= lastRow ? '0 : cursorRow + 1'b1;
                        end else if (curByte == consolePkg::charBs) begin
                            if (cursorCol != '0) begin
                                cursorCol <= cursorCol - 1'b1;
                            end
                        end else if (curByte == consolePkg::charEsc) begin
                            state <= escape;
                        end
                    end
                end
                escape: begin
                    if (pop) begin
                        state <= (curByte == consolePkg::charBracket) ? csi : ground;
                    end
                end
                csi: begin
                    if (pop) begin
                        state <= ground;
                        if (curByte == consolePkg::charHome) begin
                            cursorRow <= '0;
                            cursorCol <= '0;
                        end else if (curByte == consolePkg::charClear) begin
                            state <= clearing;
                            sweep <= '0;
                        end
                    end
                end
                clearing: begin
                    // one cell per cycle, home once the last cell is written
                    sweep <= sweep + 1'b1;
                    if (sweep == consolePkg::cellAddrWidth'(consolePkg::screenCells - 1)) begin
                        state <= ground;
                        cursorRow <= '0;
                        cursorCol <= '0;
                    end
                end
                default: state <= ground;
            endcase
        end
    end

endmodule

/* design/consolePkg.sv */
package consolePkg;

    // screen geometry
    localparam int screenCols = 32;
    localparam int screenRows = 8;
    localparam int screenCells = screenCols * screenRows;

    // index widths
    localparam int colWidth = $clog2(screenCols);
    localparam int rowWidth = $clog2(screenRows);
    // row * screenCols + col
    localparam int cellAddrWidth = $clog2(screenCells);

    // uart bit period in clk cycles
    localparam int clocksPerBit = 8;

    // byte queue entries
    localparam int queueDepth = 4;
    // parser input slots, also initial credit count
    localparam int parserSlots = 2;

    // fill code for a clear
    localparam logic [7:0] charSpace = 8'h20;

    // control bytes
    localparam logic [7:0] charCr = 8'h0D;
    localparam logic [7:0] charLf = 8'h0A;
    localparam logic [7:0] charBs = 8'h08;
    localparam logic [7:0] charEsc = 8'h1B;
    localparam logic [7:0] charBracket = 8'h5B;

    // csi final bytes
    localparam logic [7:0] charHome = 8'h48;
    localparam logic [7:0] charClear = 8'h4A;

    // printable range
    localparam logic [7:0] charFirstPrint = 8'h20;
    localparam logic [7:0] charLastPrint = 8'h7E;

endpackage

/* tb/VirtualConsoleTb.sv */
`timescale 1ns/1ns

module VirtualConsoleTb;

    localparam int numCols = consolePkg::screenCols;
    localparam int numRows = consolePkg::screenRows;
    localparam int numCells = consolePkg::screenCells;
    localparam int bitCycles = consolePkg::clocksPerBit;
    localparam int settleCycles = 400;
    localparam int numSteps = 10;

    // one table row: optional random filler first, then the literal bytes
    typedef struct {
        string bytes;
        int    fill;
        bit    badStop;
        int    expRow;
        int    expCol;
        int    cellAddr [4];
        string cellChar;
    } step_t;

    logic clk;
    logic arstN;
    logic uartRx;
    logic [consolePkg::cellAddrWidth-1:0] readAddr;
    logic [7:0] readData;
    logic [consolePkg::rowWidth-1:0] cursorRow;
    logic [consolePkg::colWidth-1:0] cursorCol;

    step_t steps [numSteps];
    int unsigned lcgState = 45508;
    int watchCycles = 0;
    int errors = 0;
    int checks = 0;

    // reference screen, x until the first clear
    logic [7:0] refScreen [numCells];
    int refRow = 0;
    int refCol = 0;
    // 0 ground, 1 after ESC, 2 after ESC [
    int refState = 0;

    VirtualConsole u_dut (
        .clk       (clk),
        .arstN     (arstN),
        .uartRx    (uartRx),
        .readAddr  (readAddr),
        .readData  (readData),
        .cursorRow (cursorRow),
        .cursorCol (cursorCol)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // '?' in cellChar means expected value comes from the model
    task automatic loadTable();
        steps[0] = '{"\033[J", 0, 1'b0, 0, 0, '{0, 31, 224, 255}, "    "};
        steps[1] = '{"Hello", 0, 1'b0, 0, 5, '{0, 1, 4, 5}, "Heo "};
        steps[2] = '{"\015\012ab\010\010\010X\012Z\001\177", 0, 1'b0, 2, 2,
                     '{32, 33, 65, 64}, "XbZ "};
        steps[3] = '{"\033[Hq", 0, 1'b0, 0, 1, '{0, 1, 32, 65}, "qeXZ"};
        steps[4] = '{"\033[Q!", 0, 1'b0, 0, 2, '{0, 1, 2, 3}, "q!ll"};
        steps[5] = '{"W", 0, 1'b1, 0, 2, '{2, 0, 5, 1}, "lq !"};
        steps[6] = '{"#", 30, 1'b0, 1, 1, '{2, 31, 32, 33}, "??#b"};
        steps[7] = '{"\012\012\012\012\012\012", 0, 1'b0, 7, 1, '{224, 225, 32, 255}, "  # "};
        steps[8] = '{"%", 31, 1'b0, 0, 1, '{225, 255, 0, 224}, "??% "};
        steps[9] = '{"\033[JABCDEFG", 0, 1'b0, 0, 7, '{0, 6, 7, 255}, "AG  "};
    endtask

    // filler text, printable range only
    function automatic logic [7:0] nextPrintable();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return 8'h20 + 8'((lcgState >> 16) % 95);
    endfunction

    task automatic advanceRow();
        refRow = (refRow + 1) % numRows;
    endtask

    // terminal rules applied to one good byte
    task automatic modelByte(input logic [7:0] b);
        if (refState == 1) begin
            refState = (b == 8'h5B) ? 2 : 0;
        end else if (refState == 2) begin
            refState = 0;
            if (b == 8'h4A) begin
                for (int i = 0; i < numCells; i++) begin
                    refScreen[i] = 8'h20;
                end
            end
            if (b == 8'h48 || b == 8'h4A) begin
                refRow = 0;
                refCol = 0;
            end
        end else if (b >= 8'h20 && b <= 8'h7E) begin
            refScreen[refRow * numCols + refCol] = b;
            if (refCol == numCols - 1) begin
                refCol = 0;
                advanceRow();
            end else begin
                refCol++;
            end
        end else if (b == 8'h0D) begin
            refCol = 0;
        end else if (b == 8'h0A) begin
            advanceRow();
        end else if (b == 8'h08 && refCol > 0) begin
            refCol--;
        end else if (b == 8'h1B) begin
            refState = 1;
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic waitCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // start, 8 data bits lsb first, stop
    task automatic sendFrame(input logic [7:0] b, input bit badStop);
        uartRx = 1'b0;
        waitCycles(bitCycles);
        for (int i = 0; i < 8; i++) begin
            uartRx = b[i];
            waitCycles(bitCycles);
        end
        uartRx = ~badStop;
        waitCycles(bitCycles);
        uartRx = 1'b1;
        // line idles a bit after a broken frame
        if (badStop) begin
            waitCycles(bitCycles);
        end else begin
            modelByte(b);
        end
    endtask

    task automatic readCell(input int addr, output logic [7:0] data);
        readAddr = consolePkg::cellAddrWidth'(addr);
        waitCycles(1);
        data = readData;
    endtask

    task automatic checkCell(input int addr, input logic [7:0] want);
        logic [7:0] got;
        readCell(addr, got);
        checks++;
        assert (got === want) else begin
            $display("Fail %0t: cell %0d read %h, expected %h", $time, addr, got, want);
            errors++;
        end
    endtask

    // timeout sized from the table contents
    initial begin
        wait (watchCycles > 0);
        repeat (watchCycles) @(posedge clk);
        $display("Error: simulation timed out after %0d cycles", watchCycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        int limit;
        logic [7:0] want;
        arstN = 1'b0;
        uartRx = 1'b1;
        readAddr = '0;
        loadTable();
        limit = 2000 + numCells * 2;
        for (int s = 0; s < numSteps; s++) begin
            limit += (steps[s].bytes.len() + steps[s].fill) * 11 * bitCycles + settleCycles + 8;
        end
        watchCycles = limit;
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
        waitCycles(4);

        for (int s = 0; s < numSteps; s++) begin
            for (int i = 0; i < steps[s].fill; i++) begin
                sendFrame(nextPrintable(), steps[s].badStop);
            end
            for (int i = 0; i < steps[s].bytes.len(); i++) begin
                sendFrame(steps[s].bytes[i], steps[s].badStop);
            end
            // covers the clear sweep plus queue drain
            waitCycles(settleCycles);
            checks++;
            assert (cursorRow == consolePkg::rowWidth'(steps[s].expRow) &&
                    cursorCol == consolePkg::colWidth'(steps[s].expCol)) else begin
                $display("Fail %0t: step %0d cursor %0d,%0d, expected %0d,%0d", $time, s,
                         cursorRow, cursorCol, steps[s].expRow, steps[s].expCol);
                errors++;
            end
            for (int k = 0; k < 4; k++) begin
                want = steps[s].cellChar[k];
                if (want == 8'h3F) begin
                    want = refScreen[steps[s].cellAddr[k]];
                end
                checkCell(steps[s].cellAddr[k], want);
            end
        end

        // whole screen against the model
        for (int a = 0; a < numCells; a++) begin
            checkCell(a, refScreen[a]);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
